//--- mipsCore_stimulus.txt
// word 0 program length, word 1 trace length, then program words by index
// then expected writeback trace as register / value pairs
00000021 00000016
// 0-5 addi, add, sub, and, or with forwarding
20010005 2022FFFD 00221820 00612022 00642824 00A13025
// 6-11 slt, ori/andi zero-extend, addi/slti sign-extend
0043382A 0062402A 34098001 312AFFFF 200BFFFF 296C0000
// 12-17 slti, lui, ori, addi to r0, read of r0, addi r16
282DFFFE 3C0E1234 35CE5678 20200007 00017820 20100003
// 18-23 beq not taken, bne taken, skipped, addi, beq taken, skipped
12020005 16010001 20110063 20120002 12420001 2013004D
// 24-29 bne not taken, addi, j, skipped, jal, skipped
16420001 2014000B 0800001C 20150037 0C00001F 20160042
// 30-32 skipped by jal, add with r31, sub
20170058 03F4C020 030FC822
// expected trace
01 00000005 02 00000002
03 00000007 04 00000002
05 00000002 06 00000007
07 00000001 08 00000000
09 00008001 0A 00008001
0B FFFFFFFF 0C 00000001
0D 00000000 0E 12340000
0E 12345678 0F 00000005
10 00000003 12 00000002
14 0000000B 1F 00000074
18 0000007F 19 0000007A

//--- mipsCore.f
mipsCorePkg.sv
registerFile.sv
instructionDecoder.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
hazardUnit.sv
mipsCore.sv
mipsCore_sva.sv
mipsCore_tb.sv

//--- mipsCore_tb.sv
`timescale 1ns/1ps

module mipsCore_tb import mipsCorePkg::*; ();

	logic CLK;
	logic rstN;
	logic [dataWidth-1:0] fetchPc;
	logic [dataWidth-1:0] fetchInstr;
	logic wbValid;
	logic [regAddrWidth-1:0] wbReg;
	logic [dataWidth-1:0] wbData;

	// counts in words 0 and 1 followed by program words and reg/value pairs
	logic [31:0] stim [0:255];
	int progLen;
	int traceLen;
	int traceIdx;
	int errorCount;
	int testsRun;
	int testsFailed;
	int cycleCount;
	int cycleLimit;

	mipsCore dut_i (
		.CLK(CLK), .rstN(rstN), .fetchPc(fetchPc), .fetchInstr(fetchInstr),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic logic [31:0] programWord(input logic [31:0] pc);
		logic [31:0] index;
		index = pc >> 2;
		if (index < progLen) begin
			return stim[2 + index];
		end
		// all-zero word past the end of the program
		return '0;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR: time %0t %s = %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testsRun++;
		if (errorCount == errorsBefore) begin
			$display("test %0d %s: PASS", testsRun, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: FAIL, %0d errors", testsRun, name,
				errorCount - errorsBefore);
		end
	endtask

	// waits until the monitor has checked the entries before lastEntry
	task automatic checkTraceSegment(input string name, input int lastEntry);
		int errorsBefore;
		errorsBefore = errorCount;
		while (traceIdx < lastEntry && traceIdx < traceLen) begin
			@(posedge CLK);
		end
		reportTest(name, errorsBefore);
	endtask

	// instruction memory answers shortly after each edge
	always @(posedge CLK) begin
		#1 fetchInstr = programWord(fetchPc);
	end

	// writeback trace sampled mid-cycle
	always @(negedge CLK) begin
		if (rstN === 1'b1 && wbValid !== 1'b0) begin
			if (traceIdx < traceLen) begin
				checkValue("wbReg", wbReg, stim[2 + progLen + 2 * traceIdx]);
				checkValue("wbData", wbData, stim[3 + progLen + 2 * traceIdx]);
				traceIdx++;
			end else begin
				// any write past the end of the trace is extra
				checkValue("wbValid", wbValid, 32'd0);
			end
		end
	end

	initial begin
		cycleCount = 0;
		wait (cycleLimit > 0);
		while (cycleCount < cycleLimit) begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, trace stopped at entry %0d of %0d",
			cycleLimit, traceIdx, traceLen);
		$display("Test failures found");
		$finish;
	end

	initial begin
		int errorsBefore;
		rstN = 1'b0;
		fetchInstr = '0;
		errorCount = 0;
		testsRun = 0;
		testsFailed = 0;
		traceIdx = 0;
		cycleLimit = 0;
		$readmemh("mipsCore_stimulus.txt", stim);
		progLen = stim[0];
		traceLen = stim[1];
		if (progLen == 0 || traceLen == 0) begin
			$display("Stimulus file is missing or holds no program or trace");
			$display("Test failures found");
			$finish;
		end else begin
			cycleLimit = 4 * progLen + 20;

			errorsBefore = errorCount;
			@(negedge CLK);
			checkValue("fetchPc", fetchPc, 32'd0);
			checkValue("wbValid", wbValid, 32'd0);
			repeat (3) @(posedge CLK);
			#1 rstN = 1'b1;
			// first write shows up on the fourth edge after release
			repeat (4) begin
				@(negedge CLK);
				checkValue("wbValid", wbValid, 32'd0);
			end
			reportTest("reset and pipeline fill", errorsBefore);

			// segment ends follow the trace layout in the stimulus file
			checkTraceSegment("dependent R-type arithmetic", 8);
			checkTraceSegment("immediate extension and lui", 15);
			checkTraceSegment("register 0 and branches", 19);
			checkTraceSegment("jump and link", traceLen);

			errorsBefore = errorCount;
			repeat (10) @(posedge CLK);
			reportTest("no writes after program", errorsBefore);

			$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed,
				errorCount);
			if (testsFailed == 0 && errorCount == 0) begin
				$display("All tests passed!");
			end else begin
				$display("Test failures found");
			end
			$finish;
		end
	end

endmodule

//--- mipsCore_sva.sv
`timescale 1ns/1ps

module hazardChecks import mipsCorePkg::*; (
	input logic                    CLK,
	input logic                    rstN,
	input logic                    stall,
	input logic                    flushD,
	input fwdSelT                  fwdA,
	input fwdSelT                  fwdB,
	input logic                    fwdBranchA,
	input logic                    fwdBranchB,
	input logic [regAddrWidth-1:0] destM,
	input logic [regAddrWidth-1:0] wbReg
);
	// producer leaves execute after one cycle
	stallSingle: assert property (@(posedge CLK) disable iff (!rstN) stall |=> !stall)
		else $error("stall held for two cycles");

	noFlushInStall: assert property (@(posedge CLK) disable iff (!rstN) !(stall && flushD))
		else $error("flushD raised while stalled");

	memFwdNonZero: assert property (@(posedge CLK) disable iff (!rstN)
		(fwdA == fwdMem || fwdB == fwdMem || fwdBranchA || fwdBranchB) |-> destM != '0)
		else $error("forward from memory stage with destination r0");

	wbFwdNonZero: assert property (@(posedge CLK) disable iff (!rstN)
		(fwdA == fwdWb || fwdB == fwdWb) |-> wbReg != '0)
		else $error("forward from writeback stage with destination r0");

endmodule

// hazard unit outputs as seen in the core
bind mipsCore hazardChecks hazardChecks_i (
	.CLK(CLK), .rstN(rstN), .stall(stall), .flushD(flushD), .fwdA(fwdA), .fwdB(fwdB),
	.fwdBranchA(fwdBranchA), .fwdBranchB(fwdBranchB), .destM(destM), .wbReg(wbReg)
);

//--- mipsCore.sv
`timescale 1ns/1ps

module mipsCore import mipsCorePkg::*; (
	input  logic                    CLK,
	input  logic                    rstN,
	output logic [dataWidth-1:0]    fetchPc,
	input  logic [dataWidth-1:0]    fetchInstr,
	output logic                    wbValid,
	output logic [regAddrWidth-1:0] wbReg,
	output logic [dataWidth-1:0]    wbData
);
	logic stall, flushD, redirect, branchD, regWriteE, regWriteM;
	logic fwdBranchA, fwdBranchB, luiSelE, linkE;
	logic [dataWidth-1:0] redirectPc, instrD, pcPlus4D, rdA, rdB, resultM;
	logic [dataWidth-1:0] rdAE, rdBE, sextImmE, zextImmE, upperImmE, pcPlus4E;
	logic [regAddrWidth-1:0] rsD, rtD, rsE, rtE, destE, destM;
	aluOpT aluOpE;
	srcBSelT srcBSelE;
	fwdSelT fwdA, fwdB;

	fetchStage fetch_i (
		.CLK(CLK), .rstN(rstN), .stall(stall), .flushD(flushD),
		.redirect(redirect), .redirectPc(redirectPc), .fetchInstr(fetchInstr),
		.fetchPc(fetchPc), .instrD(instrD), .pcPlus4D(pcPlus4D)
	);

	decodeStage decode_i (
		.CLK(CLK), .rstN(rstN), .stall(stall), .instrD(instrD), .pcPlus4D(pcPlus4D),
		.rdA(rdA), .rdB(rdB), .fwdBranchA(fwdBranchA), .fwdBranchB(fwdBranchB),
		.resultM(resultM), .rsD(rsD), .rtD(rtD), .branchD(branchD), .rsE(rsE),
		.rtE(rtE), .destE(destE), .regWriteE(regWriteE), .rdAE(rdAE), .rdBE(rdBE),
		.sextImmE(sextImmE), .zextImmE(zextImmE), .upperImmE(upperImmE),
		.pcPlus4E(pcPlus4E), .aluOpE(aluOpE), .srcBSelE(srcBSelE), .luiSelE(luiSelE),
		.linkE(linkE), .redirect(redirect), .redirectPc(redirectPc), .flushD(flushD)
	);

	// writeback drives the write port
	registerFile regFile_i (
		.CLK(CLK), .rstN(rstN), .rsD(rsD), .rtD(rtD), .we(wbValid),
		.wReg(wbReg), .wData(wbData), .rdA(rdA), .rdB(rdB)
	);

	executeStage execute_i (
		.CLK(CLK), .rstN(rstN), .rdAE(rdAE), .rdBE(rdBE), .sextImmE(sextImmE),
		.zextImmE(zextImmE), .upperImmE(upperImmE), .pcPlus4E(pcPlus4E),
		.aluOpE(aluOpE), .srcBSelE(srcBSelE), .luiSelE(luiSelE), .linkE(linkE),
		.regWriteE(regWriteE), .destE(destE), .fwdA(fwdA), .fwdB(fwdB),
		.resultM(resultM), .destM(destM), .regWriteM(regWriteM), .wbValid(wbValid),
		.wbReg(wbReg), .wbData(wbData)
	);

	hazardUnit hazard_i (
		.rsD(rsD), .rtD(rtD), .branchD(branchD), .rsE(rsE), .rtE(rtE),
		.destE(destE), .regWriteE(regWriteE), .destM(destM), .regWriteM(regWriteM),
		.wbReg(wbReg), .wbValid(wbValid), .stall(stall), .fwdA(fwdA), .fwdB(fwdB),
		.fwdBranchA(fwdBranchA), .fwdBranchB(fwdBranchB)
	);

endmodule

//--- hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import mipsCorePkg::*; (
	input  logic [regAddrWidth-1:0] rsD,
	input  logic [regAddrWidth-1:0] rtD,
	input  logic                    branchD,
	input  logic [regAddrWidth-1:0] rsE,
	input  logic [regAddrWidth-1:0] rtE,
	input  logic [regAddrWidth-1:0] destE,
	input  logic                    regWriteE,
	input  logic [regAddrWidth-1:0] destM,
	input  logic                    regWriteM,
	input  logic [regAddrWidth-1:0] wbReg,
	input  logic                    wbValid,
	output logic                    stall,
	output fwdSelT                  fwdA,
	output fwdSelT                  fwdB,
	output logic                    fwdBranchA,
	output logic                    fwdBranchB
);
	logic memWrites;

	// wbValid already excludes r0
	assign memWrites = regWriteM && destM != '0;

	always_comb begin
		// memory stage holds the younger value, so it wins
		if (memWrites && destM == rsE) fwdA = fwdMem;
		else if (wbValid && wbReg == rsE) fwdA = fwdWb;
		else fwdA = fwdReg;

		if (memWrites && destM == rtE) fwdB = fwdMem;
		else if (wbValid && wbReg == rtE) fwdB = fwdWb;
		else fwdB = fwdReg;
	end

	assign fwdBranchA = memWrites && destM == rsD;
	assign fwdBranchB = memWrites && destM == rtD;

	// branch operand still being computed in execute
	assign stall = branchD && regWriteE && destE != '0 &&
		(destE == rsD || destE == rtD);

endmodule

//--- executeStage.sv
`timescale 1ns/1ps

module executeStage import mipsCorePkg::*; (
	input  logic                    CLK,
	input  logic                    rstN,
	input  logic [dataWidth-1:0]    rdAE,
	input  logic [dataWidth-1:0]    rdBE,
	input  logic [dataWidth-1:0]    sextImmE,
	input  logic [dataWidth-1:0]    zextImmE,
	input  logic [dataWidth-1:0]    upperImmE,
	input  logic [dataWidth-1:0]    pcPlus4E,
	input  aluOpT                   aluOpE,
	input  srcBSelT                 srcBSelE,
	input  logic                    luiSelE,
	input  logic                    linkE,
	input  logic                    regWriteE,
	input  logic [regAddrWidth-1:0] destE,
	input  fwdSelT                  fwdA,
	input  fwdSelT                  fwdB,
	output logic [dataWidth-1:0]    resultM,
	output logic [regAddrWidth-1:0] destM,
	output logic                    regWriteM,
	output logic                    wbValid,
	output logic [regAddrWidth-1:0] wbReg,
	output logic [dataWidth-1:0]    wbData
);
	logic [dataWidth-1:0] srcA, regB, srcB, aluOut, resultE;

	always_comb begin
		case (fwdA)
			fwdMem: srcA = resultM;
			fwdWb: srcA = wbData;
			default: srcA = rdAE;
		endcase
		case (fwdB)
			fwdMem: regB = resultM;
			fwdWb: regB = wbData;
			default: regB = rdBE;
		endcase
	end

	always_comb begin
		case (srcBSelE)
			srcSext: srcB = sextImmE;
			srcZext: srcB = zextImmE;
			default: srcB = regB;
		endcase
	end

	always_comb begin
		case (aluOpE)
			aluSub: aluOut = srcA - srcB;
			aluAnd: aluOut = srcA & srcB;
			aluOr: aluOut = srcA | srcB;
			// signed compare
			aluSlt: aluOut = {{(dataWidth - 1){1'b0}}, $signed(srcA) < $signed(srcB)};
			default: aluOut = srcA + srcB;
		endcase
	end

	// jal links the return address, lui bypasses the ALU
	assign resultE = linkE ? pcPlus4E : (luiSelE ? upperImmE : aluOut);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			regWriteM <= 1'b0;
			wbValid <= 1'b0;
		end else begin
			regWriteM <= regWriteE;
			wbValid <= regWriteM && destM != '0;
		end
	end

	always_ff @(posedge CLK) begin
		resultM <= resultE;
		destM <= destE;
		wbData <= resultM;
		wbReg <= destM;
	end

endmodule

//--- decodeStage.sv
`timescale 1ns/1ps

module decodeStage import mipsCorePkg::*; (
	input  logic                    CLK,
	input  logic                    rstN,
	input  logic                    stall,
	input  logic [dataWidth-1:0]    instrD,
	input  logic [dataWidth-1:0]    pcPlus4D,
	input  logic [dataWidth-1:0]    rdA,
	input  logic [dataWidth-1:0]    rdB,
	input  logic                    fwdBranchA,
	input  logic                    fwdBranchB,
	input  logic [dataWidth-1:0]    resultM,
	output logic [regAddrWidth-1:0] rsD,
	output logic [regAddrWidth-1:0] rtD,
	output logic                    branchD,
	output logic [regAddrWidth-1:0] rsE,
	output logic [regAddrWidth-1:0] rtE,
	output logic [regAddrWidth-1:0] destE,
	output logic                    regWriteE,
	output logic [dataWidth-1:0]    rdAE,
	output logic [dataWidth-1:0]    rdBE,
	output logic [dataWidth-1:0]    sextImmE,
	output logic [dataWidth-1:0]    zextImmE,
	output logic [dataWidth-1:0]    upperImmE,
	output logic [dataWidth-1:0]    pcPlus4E,
	output aluOpT                   aluOpE,
	output srcBSelT                 srcBSelE,
	output logic                    luiSelE,
	output logic                    linkE,
	output logic                    redirect,
	output logic [dataWidth-1:0]    redirectPc,
	output logic                    flushD
);
	logic regWriteD, regDstD, luiSelD, branchEqD, branchNeD, jumpD, linkD;
	aluOpT aluOpD;
	srcBSelT srcBSelD;
	logic [regAddrWidth-1:0] destD;
	logic [dataWidth-1:0] sextImmD, zextImmD, upperImmD;
	logic [dataWidth-1:0] cmpA, cmpB, branchTarget, jumpTarget;
	logic takenD;

	instructionDecoder decoder_i (
		.opcode(instrD[31:26]),
		.funct(instrD[5:0]),
		.regWrite(regWriteD),
		.regDst(regDstD),
		.aluOp(aluOpD),
		.srcBSel(srcBSelD),
		.luiSel(luiSelD),
		.branchEq(branchEqD),
		.branchNe(branchNeD),
		.jump(jumpD),
		.link(linkD)
	);

	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign destD = linkD ? linkReg : (regDstD ? instrD[15:11] : instrD[20:16]);

	assign sextImmD = {{16{instrD[15]}}, instrD[15:0]};
	assign zextImmD = {16'b0, instrD[15:0]};
	assign upperImmD = {instrD[15:0], 16'b0};

	// memory-stage bypass for the branch compare
	assign cmpA = fwdBranchA ? resultM : rdA;
	assign cmpB = fwdBranchB ? resultM : rdB;

	assign branchD = branchEqD | branchNeD;
	assign takenD = (branchEqD && cmpA == cmpB) || (branchNeD && cmpA != cmpB);

	assign branchTarget = pcPlus4D + {sextImmD[dataWidth-3:0], 2'b00};
	assign jumpTarget = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	// operands are stale while stalled, so no redirect then
	assign flushD = !stall && (jumpD || takenD);
	assign redirect = flushD;
	assign redirectPc = jumpD ? jumpTarget : branchTarget;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			regWriteE <= 1'b0;
			luiSelE <= 1'b0;
			linkE <= 1'b0;
			aluOpE <= aluAdd;
			srcBSelE <= srcReg;
			destE <= '0;
			rsE <= '0;
			rtE <= '0;
		end else if (stall) begin
			// bubble into execute
			regWriteE <= 1'b0;
			luiSelE <= 1'b0;
			linkE <= 1'b0;
			aluOpE <= aluAdd;
			srcBSelE <= srcReg;
			destE <= '0;
			rsE <= '0;
			rtE <= '0;
		end else begin
			regWriteE <= regWriteD;
			luiSelE <= luiSelD;
			linkE <= linkD;
			aluOpE <= aluOpD;
			srcBSelE <= srcBSelD;
			destE <= destD;
			rsE <= rsD;
			rtE <= rtD;
		end
	end

	always_ff @(posedge CLK) begin
		rdAE <= rdA;
		rdBE <= rdB;
		sextImmE <= sextImmD;
		zextImmE <= zextImmD;
		upperImmE <= upperImmD;
		pcPlus4E <= pcPlus4D;
	end

endmodule

//--- fetchStage.sv
`timescale 1ns/1ps

module fetchStage import mipsCorePkg::*; (
	input  logic                 CLK,
	input  logic                 rstN,
	input  logic                 stall,
	input  logic                 flushD,
	input  logic                 redirect,
	input  logic [dataWidth-1:0] redirectPc,
	input  logic [dataWidth-1:0] fetchInstr,
	output logic [dataWidth-1:0] fetchPc,
	output logic [dataWidth-1:0] instrD,
	output logic [dataWidth-1:0] pcPlus4D
);
	logic [dataWidth-1:0] pcPlus4F;
	logic [dataWidth-1:0] nextPc;

	assign pcPlus4F = fetchPc + dataWidth'(4);
	assign nextPc = redirect ? redirectPc : pcPlus4F;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			fetchPc <= '0;
		end else if (!stall) begin
			fetchPc <= nextPc;
		end
	end

	// all-zero word decodes to an instruction with no effect
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			instrD <= '0;
		end else if (flushD) begin
			instrD <= '0;
		end else if (!stall) begin
			instrD <= fetchInstr;
		end
	end

	always_ff @(posedge CLK) begin
		if (!stall) begin
			pcPlus4D <= pcPlus4F;
		end
	end

endmodule

//--- instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder import mipsCorePkg::*; (
	input  logic [5:0] opcode,
	input  logic [5:0] funct,
	output logic       regWrite,
	output logic       regDst,
	output aluOpT      aluOp,
	output srcBSelT    srcBSel,
	output logic       luiSel,
	output logic       branchEq,
	output logic       branchNe,
	output logic       jump,
	output logic       link
);
	always_comb begin
		// anything not listed below writes nothing
		regWrite = 1'b0;
		regDst = 1'b0;
		aluOp = aluAdd;
		srcBSel = srcReg;
		luiSel = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		jump = 1'b0;
		link = 1'b0;
		case (opcode)
			opRType: begin
				regDst = 1'b1;
				regWrite = 1'b1;
				case (funct)
					functAdd: aluOp = aluAdd;
					functSub: aluOp = aluSub;
					functAnd: aluOp = aluAnd;
					functOr: aluOp = aluOr;
					functSlt: aluOp = aluSlt;
					default: regWrite = 1'b0;
				endcase
			end
			opAddi: begin
				regWrite = 1'b1;
				srcBSel = srcSext;
			end
			opSlti: begin
				regWrite = 1'b1;
				srcBSel = srcSext;
				aluOp = aluSlt;
			end
			opAndi: begin
				regWrite = 1'b1;
				srcBSel = srcZext;
				aluOp = aluAnd;
			end
			opOri: begin
				regWrite = 1'b1;
				srcBSel = srcZext;
				aluOp = aluOr;
			end
			opLui: begin
				regWrite = 1'b1;
				luiSel = 1'b1;
			end
			opBeq: branchEq = 1'b1;
			opBne: branchNe = 1'b1;
			opJ: jump = 1'b1;
			opJal: begin
				jump = 1'b1;
				link = 1'b1;
				regWrite = 1'b1;
			end
			default: regWrite = 1'b0;
		endcase
	end

endmodule

//--- registerFile.sv
`timescale 1ns/1ps

module registerFile import mipsCorePkg::*; (
	input  logic                    CLK,
	input  logic                    rstN,
	input  logic [regAddrWidth-1:0] rsD,
	input  logic [regAddrWidth-1:0] rtD,
	input  logic                    we,
	input  logic [regAddrWidth-1:0] wReg,
	input  logic [dataWidth-1:0]    wData,
	output logic [dataWidth-1:0]    rdA,
	output logic [dataWidth-1:0]    rdB
);
	logic [dataWidth-1:0] regs [0:(1 << regAddrWidth) - 1];

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < (1 << regAddrWidth); i++) begin
				regs[i] <= '0;
			end
		end else if (we && wReg != '0) begin
			regs[wReg] <= wData;
		end
	end

	// r0 is hardwired, writeback bypasses straight to decode
	assign rdA = (rsD == '0) ? '0 :
		(we && wReg == rsD) ? wData : regs[rsD];
	assign rdB = (rtD == '0) ? '0 :
		(we && wReg == rtD) ? wData : regs[rtD];

endmodule

//--- mipsCorePkg.sv
package mipsCorePkg;

	// datapath and register index widths
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	// jal link destination
	localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

	// primary opcodes, instr[31:26]
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opJal = 6'h03;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opSlti = 6'h0a;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;

	// R-type function codes, instr[5:0]
	localparam logic [5:0] functAdd = 6'h20;
	localparam logic [5:0] functSub = 6'h22;
	localparam logic [5:0] functAnd = 6'h24;
	localparam logic [5:0] functOr = 6'h25;
	localparam logic [5:0] functSlt = 6'h2a;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpT;

	// second ALU operand source
	typedef enum logic [1:0] {
		srcReg,
		srcSext,
		srcZext
	} srcBSelT;

	// operand bypass source in execute
	typedef enum logic [1:0] {
		fwdReg,
		fwdMem,
		fwdWb
	} fwdSelT;

endpackage
